// File: design/cmd_seq_pkg.sv
`default_nettype none

package cmd_seq_pkg;

    // sequencer FSM
    typedef enum logic {
        IDLE = 1'b0,
        SEND = 1'b1
    } cmd_seq_state_e;

    // serial line coding, mode 1 falls back to plain NRZ
    typedef enum logic [1:0] {
        MODE_NRZ          = 2'd0,
        MODE_NRZ_ALT      = 2'd1,
        MODE_MANCH_IEEE   = 2'd2,
        MODE_MANCH_THOMAS = 2'd3
    } cmd_out_mode_e;

    localparam int ADDR_W = 16;
    localparam int SIZE_W = 16;
    localparam int REP_W = 32;

    localparam logic [7:0] VERSION = 8'd1;

    // register map
    localparam logic [ADDR_W-1:0] ADDR_CTRL0 = 16'd0;
    localparam logic [ADDR_W-1:0] ADDR_START = 16'd1;
    localparam logic [ADDR_W-1:0] ADDR_CONF = 16'd2;
    localparam logic [ADDR_W-1:0] ADDR_SIZE_LO = 16'd3;
    localparam logic [ADDR_W-1:0] ADDR_SIZE_HI = 16'd4;
    localparam logic [ADDR_W-1:0] ADDR_REP0 = 16'd5;
    localparam logic [ADDR_W-1:0] ADDR_REP1 = 16'd6;
    localparam logic [ADDR_W-1:0] ADDR_REP2 = 16'd7;
    localparam logic [ADDR_W-1:0] ADDR_REP3 = 16'd8;
    localparam logic [ADDR_W-1:0] ADDR_START_REP_LO = 16'd9;
    localparam logic [ADDR_W-1:0] ADDR_START_REP_HI = 16'd10;
    localparam logic [ADDR_W-1:0] ADDR_STOP_REP_LO = 16'd11;
    localparam logic [ADDR_W-1:0] ADDR_STOP_REP_HI = 16'd12;
    localparam logic [ADDR_W-1:0] ADDR_OUT_EN = 16'd13;
    localparam logic [ADDR_W-1:0] ADDR_MEM_BASE = 16'd16;

    // bit positions inside the conf byte
    localparam int CONF_EXT_START = 0;
    localparam int CONF_MODE_LSB = 1;
    localparam int CONF_DIS_PULSE = 4;

    localparam logic [7:0] REP0_DEFAULT = 8'd1;
    localparam logic [7:0] OUT_EN_DEFAULT = 8'hff;

endpackage

`default_nettype wire

// File: design/cmd_seq_regs.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_seq_regs #(
    parameter int CMD_MEM_SIZE = 2048
) (
    input  logic                              CMD_CLK_IN,
    input  logic                              RST_CMD_CLK,
    input  logic                              req,
    input  logic                              we,
    input  logic [cmd_seq_pkg::ADDR_W-1:0]    addr,
    input  logic [7:0]                        wdata,
    input  logic [7:0]                        mem_rdata,
    input  logic                              done,
    input  logic                              ext_start,
    output logic                              ack,
    output logic [7:0]                        rdata,
    output logic                              start,
    output logic                              soft_rst,
    output logic                              mem_we,
    output logic [$clog2(CMD_MEM_SIZE)-1:0]   mem_addr,
    output logic [7:0]                        mem_wdata,
    output logic                              ext_start_enable,
    output logic [cmd_seq_pkg::SIZE_W-1:0]    size,
    output logic [cmd_seq_pkg::REP_W-1:0]     repeat_count,
    output logic [cmd_seq_pkg::SIZE_W-1:0]    start_repeat,
    output logic [cmd_seq_pkg::SIZE_W-1:0]    stop_repeat,
    output cmd_seq_pkg::cmd_out_mode_e        out_mode,
    output logic                              dis_start_pulse,
    output logic [7:0]                        out_enable
);
    import cmd_seq_pkg::*;

    localparam int MEM_AW = $clog2(CMD_MEM_SIZE);

    // four-phase slave, ack two cycles after req is first seen
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_FETCH,
        HS_RESP,
        HS_ACK
    } hs_state_e;

    hs_state_e         hs_state;
    logic              access;
    logic              soft_req;
    logic              cfg_wr;
    logic              mem_hit;
    logic              ext_go;
    logic              start_q;
    logic              soft_q;
    logic              finish;
    logic [ADDR_W-1:0] mem_offset;
    logic [7:0]        cfg_q [ADDR_CONF:ADDR_OUT_EN];

    assign access = (hs_state == HS_IDLE) && req;
    assign soft_req = access && we && (addr == ADDR_CTRL0);
    assign cfg_wr = access && we && (addr >= ADDR_CONF) && (addr <= ADDR_OUT_EN);

    // memory window starts at 16
    assign mem_offset = addr - ADDR_MEM_BASE;
    assign mem_hit = (addr >= ADDR_MEM_BASE) && (mem_offset < CMD_MEM_SIZE);
    assign mem_we = access && we && mem_hit;
    assign mem_addr = mem_offset[MEM_AW-1:0];
    assign mem_wdata = wdata;

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            hs_state <= HS_IDLE;
            ack <= 1'b0;
        end else begin
            case (hs_state)
                HS_IDLE: if (req) hs_state <= HS_FETCH;
                HS_FETCH: hs_state <= HS_RESP;
                HS_RESP: begin
                    hs_state <= HS_ACK;
                    ack <= 1'b1;
                end
                HS_ACK: if (!req) begin
                    hs_state <= HS_IDLE;
                    ack <= 1'b0;
                end
                default: hs_state <= HS_IDLE;
            endcase
        end
    end

    // read data settles one cycle before ack
    always_ff @(posedge CMD_CLK_IN) begin
        if (hs_state == HS_FETCH) begin
            if (addr == ADDR_CTRL0) rdata <= VERSION;
            else if (addr == ADDR_START) rdata <= {7'b0, finish};
            else if (addr <= ADDR_OUT_EN) rdata <= cfg_q[addr[3:0]];
            else if (mem_hit) rdata <= mem_rdata;
            else rdata <= 8'h00;
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK || soft_req) begin
            for (int i = ADDR_CONF; i <= ADDR_OUT_EN; i++) begin
                cfg_q[i] <= 8'h00;
            end
            cfg_q[ADDR_REP0] <= REP0_DEFAULT;
            cfg_q[ADDR_OUT_EN] <= OUT_EN_DEFAULT;
        end else if (cfg_wr) begin
            cfg_q[addr[3:0]] <= wdata;
        end
    end

    // start and soft reset pulses
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            start_q <= 1'b0;
            soft_q <= 1'b0;
        end else begin
            start_q <= access && we && (addr == ADDR_START);
            soft_q <= soft_req;
        end
    end

    assign ext_go = ext_start && ext_start_enable;
    assign start = start_q || ext_go;
    assign soft_rst = soft_q;

    // done wins over a start that hits a running send
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK || soft_req) finish <= 1'b1;
        else if (done) finish <= 1'b1;
        else if (start) finish <= 1'b0;
    end

    assign size = {cfg_q[ADDR_SIZE_HI], cfg_q[ADDR_SIZE_LO]};
    assign repeat_count = {cfg_q[ADDR_REP3], cfg_q[ADDR_REP2], cfg_q[ADDR_REP1], cfg_q[ADDR_REP0]};
    assign start_repeat = {cfg_q[ADDR_START_REP_HI], cfg_q[ADDR_START_REP_LO]};
    assign stop_repeat = {cfg_q[ADDR_STOP_REP_HI], cfg_q[ADDR_STOP_REP_LO]};
    assign out_enable = cfg_q[ADDR_OUT_EN];
    assign ext_start_enable = cfg_q[ADDR_CONF][CONF_EXT_START];
    assign dis_start_pulse = cfg_q[ADDR_CONF][CONF_DIS_PULSE];
    assign out_mode = cmd_out_mode_e'(cfg_q[ADDR_CONF][CONF_MODE_LSB +: 2]);

    // host holds req through the whole access
    ack_after_req: assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        $rose(ack) |-> $past(req) && $past(req, 3));

endmodule

`default_nettype wire

// File: design/cmd_seq_mem.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_seq_mem #(
    parameter int CMD_MEM_SIZE = 2048
) (
    input  logic                            CMD_CLK_IN,
    input  logic                            we,
    input  logic [$clog2(CMD_MEM_SIZE)-1:0] addr,
    input  logic [7:0]                      wdata,
    input  logic [$clog2(CMD_MEM_SIZE)-1:0] rd_addr,
    output logic [7:0]                      bus_rdata,
    output logic [7:0]                      rd_data
);

    localparam int MEM_AW = $clog2(CMD_MEM_SIZE);

    logic [7:0] mem_q [CMD_MEM_SIZE];
    logic [MEM_AW-1:0] bus_idx;
    logic [MEM_AW-1:0] seq_idx;

    assign bus_idx = addr;
    assign seq_idx = rd_addr;

    // bus port, read-before-write
    always_ff @(posedge CMD_CLK_IN) begin
        if (we) begin
            mem_q[bus_idx] <= wdata;
        end
        bus_rdata <= mem_q[bus_idx];
    end

    // sequencer port, one cycle latency
    always_ff @(posedge CMD_CLK_IN) begin
        rd_data <= mem_q[seq_idx];
    end

endmodule

`default_nettype wire

// File: design/cmd_seq_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_seq_ctrl #(
    parameter int CMD_MEM_SIZE = 2048
) (
    input  logic                            CMD_CLK_IN,
    input  logic                            RST_CMD_CLK,
    input  logic                            soft_rst,
    input  logic                            start,
    input  logic [cmd_seq_pkg::SIZE_W-1:0]  size,
    input  logic [cmd_seq_pkg::REP_W-1:0]   repeat_count,
    input  logic [cmd_seq_pkg::SIZE_W-1:0]  start_repeat,
    input  logic [cmd_seq_pkg::SIZE_W-1:0]  stop_repeat,
    input  logic                            dis_start_pulse,
    input  logic                            advance,
    input  logic [7:0]                      rd_data,
    output logic [$clog2(CMD_MEM_SIZE)-1:0] rd_addr,
    output logic                            load,
    output logic [7:0]                      load_byte,
    output logic [2:0]                      bit_index,
    output logic                            active,
    output logic                            ready,
    output logic                            start_flag,
    output logic                            done
);
    import cmd_seq_pkg::*;

    localparam int MEM_AW = $clog2(CMD_MEM_SIZE);

    cmd_seq_state_e    state;
    cmd_seq_state_e    state_nxt;
    logic [SIZE_W-1:0] pos;
    logic [SIZE_W-1:0] pos_nxt;
    logic [SIZE_W-1:0] mid_last;
    logic [SIZE_W-1:0] seq_last;
    logic [SIZE_W-1:0] byte_addr;
    logic [REP_W-1:0]  pass_cnt;
    logic [REP_W-1:0]  pass_nxt;
    logic [REP_W-1:0]  passes;
    logic              go;
    logic              finish_seq;
    logic              load_q;
    logic              bit_first;
    logic              flag_s1;
    logic              idle_d1;

    // zero repeats runs the middle once
    assign passes = (repeat_count == '0) ? REP_W'(1) : repeat_count;
    assign mid_last = size - stop_repeat - SIZE_W'(1);
    assign seq_last = size - SIZE_W'(1);
    assign go = (state == IDLE) && start && !soft_rst;

    always_comb begin
        state_nxt = state;
        pos_nxt = pos;
        pass_nxt = pass_cnt;
        finish_seq = 1'b0;
        if (soft_rst) begin
            state_nxt = IDLE;
            pos_nxt = '0;
        end else if (go) begin
            state_nxt = SEND;
            pos_nxt = '0;
            pass_nxt = REP_W'(1);
        end else if (state == SEND && advance) begin
            if (pos == mid_last && pass_cnt < passes) begin
                // back to the start of the middle section
                pos_nxt = start_repeat;
                pass_nxt = pass_cnt + REP_W'(1);
            end else if (pos == seq_last) begin
                state_nxt = IDLE;
                pos_nxt = '0;
                finish_seq = 1'b1;
            end else begin
                pos_nxt = pos + SIZE_W'(1);
            end
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            state <= IDLE;
            pos <= '0;
            pass_cnt <= '0;
        end else begin
            state <= state_nxt;
            pos <= pos_nxt;
            pass_cnt <= pass_nxt;
        end
    end

    // memory is addressed with the upcoming position, so rd_data lines up with pos
    assign byte_addr = pos_nxt >> 3;
    assign rd_addr = byte_addr[MEM_AW-1:0];

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            load_q <= 1'b0;
            bit_first <= 1'b0;
            flag_s1 <= 1'b0;
            start_flag <= 1'b0;
            idle_d1 <= 1'b1;
            ready <= 1'b1;
            done <= 1'b0;
        end else begin
            // new byte whenever the byte address moves
            load_q <= (state_nxt == SEND) &&
                      (state == IDLE || pos_nxt[SIZE_W-1:3] != pos[SIZE_W-1:3]);
            bit_first <= (state_nxt == SEND) && (go || advance);
            // two stages to line up with cmd_data
            flag_s1 <= bit_first && (pos == start_repeat) &&
                       (pass_cnt == REP_W'(1)) && !dis_start_pulse;
            start_flag <= flag_s1;
            // ready waits for the serializer pipe to drain
            idle_d1 <= (state == IDLE);
            ready <= (state == IDLE) && idle_d1 && !go;
            done <= finish_seq;
        end
    end

    assign load = load_q;
    assign load_byte = rd_data;
    assign bit_index = pos[2:0];
    assign active = (state == SEND);

    flag_in_send: assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        start_flag |-> $past(state, 2) == SEND);

    // pattern has to fit into the command memory
    addr_in_mem: assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        (state == SEND) |-> byte_addr < CMD_MEM_SIZE);

endmodule

`default_nettype wire

// File: design/cmd_seq_serializer.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_seq_serializer #(
    parameter int OUTPUTS = 1
) (
    input  logic                       CMD_CLK_IN,
    input  logic                       RST_CMD_CLK,
    input  logic                       load,
    input  logic [7:0]                 load_byte,
    input  logic [2:0]                 bit_index,
    input  logic                       active,
    input  cmd_seq_pkg::cmd_out_mode_e out_mode,
    input  logic [7:0]                 out_enable,
    output logic                       advance,
    output logic [OUTPUTS-1:0]         cmd_data
);
    import cmd_seq_pkg::*;

    logic       manch;
    logic       phase;
    logic       half_q;
    logic       act_q;
    logic       ser_bit;
    logic       line_val;
    logic [7:0] byte_q;
    logic [2:0] idx_q;

    assign manch = (out_mode == MODE_MANCH_IEEE) || (out_mode == MODE_MANCH_THOMAS);

    // half-bit phase, only toggles in the Manchester modes
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            phase <= 1'b0;
        end else begin
            phase <= active && manch && !phase;
        end
    end

    assign advance = active && (!manch || phase);

    always_ff @(posedge CMD_CLK_IN) begin
        if (load) begin
            byte_q <= load_byte;
        end
        idx_q <= bit_index;
        half_q <= phase;
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            act_q <= 1'b0;
        end else begin
            act_q <= active;
        end
    end

    // msb goes first
    assign ser_bit = byte_q[3'd7 - idx_q];

    always_comb begin
        case (out_mode)
            MODE_NRZ, MODE_NRZ_ALT: line_val = ser_bit;
            // IEEE 802.3: inverted first half
            MODE_MANCH_IEEE: line_val = half_q ? ser_bit : ~ser_bit;
            // Thomas: true first half
            MODE_MANCH_THOMAS: line_val = half_q ? ~ser_bit : ser_bit;
            default: line_val = ser_bit;
        endcase
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            cmd_data <= '0;
        end else if (act_q) begin
            cmd_data <= {OUTPUTS{line_val}} & out_enable[OUTPUTS-1:0];
        end else begin
            cmd_data <= '0;
        end
    end

endmodule

`default_nettype wire

// File: design/cmd_seq_top.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_seq_top #(
    parameter int OUTPUTS = 1,
    parameter int CMD_MEM_SIZE = 2048
) (
    input  logic                           CMD_CLK_IN,
    input  logic                           RST_CMD_CLK,
    input  logic                           req,
    input  logic                           we,
    input  logic [cmd_seq_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                     wdata,
    input  logic                           cmd_ext_start,
    output logic                           ack,
    output logic [7:0]                     rdata,
    output logic [OUTPUTS-1:0]             cmd_data,
    output logic                           cmd_ready,
    output logic                           cmd_start_flag,
    output logic                           cmd_ext_start_enable
);
    import cmd_seq_pkg::*;

    localparam int MEM_AW = $clog2(CMD_MEM_SIZE);

    // bus side
    logic              start;
    logic              soft_rst;
    logic              done;
    logic              mem_we;
    logic [MEM_AW-1:0] mem_addr;
    logic [7:0]        mem_wdata;
    logic [7:0]        mem_rdata;
    // configuration
    logic [SIZE_W-1:0] size;
    logic [REP_W-1:0]  repeat_count;
    logic [SIZE_W-1:0] start_repeat;
    logic [SIZE_W-1:0] stop_repeat;
    cmd_out_mode_e     out_mode;
    logic              dis_start_pulse;
    logic [7:0]        out_enable;
    // sequencer side
    logic [MEM_AW-1:0] rd_addr;
    logic [7:0]        rd_data;
    logic              load;
    logic [7:0]        load_byte;
    logic [2:0]        bit_index;
    logic              active;
    logic              advance;

    cmd_seq_regs #(
        .CMD_MEM_SIZE(CMD_MEM_SIZE)
    ) i_regs (
        .*,
        .ext_start(cmd_ext_start),
        .ext_start_enable(cmd_ext_start_enable)
    );

    cmd_seq_mem #(
        .CMD_MEM_SIZE(CMD_MEM_SIZE)
    ) i_mem (
        .CMD_CLK_IN(CMD_CLK_IN),
        .we(mem_we),
        .addr(mem_addr),
        .wdata(mem_wdata),
        .rd_addr(rd_addr),
        .bus_rdata(mem_rdata),
        .rd_data(rd_data)
    );

    cmd_seq_ctrl #(
        .CMD_MEM_SIZE(CMD_MEM_SIZE)
    ) i_ctrl (
        .*,
        .ready(cmd_ready),
        .start_flag(cmd_start_flag)
    );

    cmd_seq_serializer #(
        .OUTPUTS(OUTPUTS)
    ) i_serializer (
        .*
    );

endmodule

`default_nettype wire

// File: tb/cmd_seq_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_seq_tb;
    import cmd_seq_pkg::*;

    localparam int OUTPUTS = 4;
    localparam int MEM_SIZE = 256;
    localparam int PATTERN_BYTES = 8;
    localparam int MAX_CYCLES = 1024;
    // run limit from access and send lengths
    localparam int ACCESS_COUNT = 200;
    localparam int ACCESS_CYCLES = 6;
    localparam int SEND_CYCLES = 600;
    localparam int LIMIT = 10 + ACCESS_COUNT * ACCESS_CYCLES + SEND_CYCLES + 500;

    logic               CMD_CLK_IN;
    logic               RST_CMD_CLK;
    logic               req;
    logic               we;
    logic [ADDR_W-1:0]  addr;
    logic [7:0]         wdata;
    logic               cmd_ext_start;
    logic               ack;
    logic [7:0]         rdata;
    logic [OUTPUTS-1:0] cmd_data;
    logic               cmd_ready;
    logic               cmd_start_flag;
    logic               cmd_ext_start_enable;

    integer             seed;
    int                 err_cnt;
    int                 tests_run;
    int                 tests_failed;
    int                 test_errs;
    int                 cycles;
    string              test_name;
    logic [7:0]         mem_model [0:PATTERN_BYTES-1];
    logic               exp_bits [0:MAX_CYCLES-1];
    int                 exp_len;
    logic [OUTPUTS-1:0] exp_line [0:MAX_CYCLES-1];
    logic               exp_flag [0:MAX_CYCLES-1];
    int                 exp_cycles;
    logic               cmp_busy;
    event               run_cmp;

    cmd_seq_top #(
        .OUTPUTS(OUTPUTS),
        .CMD_MEM_SIZE(MEM_SIZE)
    ) i_dut (
        .CMD_CLK_IN(CMD_CLK_IN),
        .RST_CMD_CLK(RST_CMD_CLK),
        .req(req),
        .we(we),
        .addr(addr),
        .wdata(wdata),
        .cmd_ext_start(cmd_ext_start),
        .ack(ack),
        .rdata(rdata),
        .cmd_data(cmd_data),
        .cmd_ready(cmd_ready),
        .cmd_start_flag(cmd_start_flag),
        .cmd_ext_start_enable(cmd_ext_start_enable)
    );

    always #4 CMD_CLK_IN = ~CMD_CLK_IN;

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL @%0t: %s read 0x%02h, expected 0x%02h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_lines(input logic [OUTPUTS-1:0] got, input logic [OUTPUTS-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("FAIL @%0t: %s cmd_data %b, expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_mode(input cmd_out_mode_e got, input cmd_out_mode_e exp,
                              input string what);
        if (got !== exp) begin
            $display("FAIL @%0t: %s mode %s, expected %s", $time, what, got.name(), exp.name());
            err_cnt++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL @%0t: %s is %b, expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // four-phase access, host side
    task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [7:0] d);
        @(negedge CMD_CLK_IN);
        addr = a;
        wdata = d;
        we = 1'b1;
        req = 1'b1;
        @(negedge CMD_CLK_IN);
        while (ack !== 1'b1) @(negedge CMD_CLK_IN);
        req = 1'b0;
        we = 1'b0;
        @(negedge CMD_CLK_IN);
        while (ack !== 1'b0) @(negedge CMD_CLK_IN);
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] a, output logic [7:0] d);
        @(negedge CMD_CLK_IN);
        addr = a;
        we = 1'b0;
        req = 1'b1;
        @(negedge CMD_CLK_IN);
        while (ack !== 1'b1) @(negedge CMD_CLK_IN);
        d = rdata;
        req = 1'b0;
        @(negedge CMD_CLK_IN);
        while (ack !== 1'b0) @(negedge CMD_CLK_IN);
    endtask

    // expected bits: prefix once, middle R times, suffix once
    function automatic void model_stream(input int n, input int s, input int t, input int r);
        exp_len = 0;
        for (int k = 0; k < s; k++) begin
            exp_bits[exp_len] = mem_model[k / 8][7 - (k % 8)];
            exp_len++;
        end
        for (int p = 0; p < r; p++) begin
            for (int k = s; k < n - t; k++) begin
                exp_bits[exp_len] = mem_model[k / 8][7 - (k % 8)];
                exp_len++;
            end
        end
        for (int k = n - t; k < n; k++) begin
            exp_bits[exp_len] = mem_model[k / 8][7 - (k % 8)];
            exp_len++;
        end
    endfunction

    function automatic logic half_value(input logic b, input cmd_out_mode_e mode, input int h);
        case (mode)
            MODE_MANCH_IEEE: return (h == 0) ? ~b : b;
            MODE_MANCH_THOMAS: return (h == 0) ? b : ~b;
            default: return b;
        endcase
    endfunction

    // one entry per output cycle
    function automatic void expand_cycles(input cmd_out_mode_e mode, input logic [7:0] out_en,
                                          input logic flag_on, input int s);
        int  cpb;
        logic v;
        cpb = (mode == MODE_MANCH_IEEE || mode == MODE_MANCH_THOMAS) ? 2 : 1;
        exp_cycles = 0;
        for (int i = 0; i < exp_len; i++) begin
            for (int h = 0; h < cpb; h++) begin
                v = half_value(exp_bits[i], mode, h);
                exp_line[exp_cycles] = {OUTPUTS{v}} & out_en[OUTPUTS-1:0];
                exp_flag[exp_cycles] = flag_on && (i == s) && (h == 0);
                exp_cycles++;
            end
        end
    endfunction

    task automatic load_pattern();
        logic [7:0] b;
        for (int i = 0; i < PATTERN_BYTES; i++) begin
            b = 8'($random(seed));
            mem_model[i] = b;
            bus_write(ADDR_MEM_BASE + ADDR_W'(i), b);
        end
    endtask

    task automatic configure_send(input int n, input int s, input int t, input int r,
                                  input logic [7:0] conf, input logic [7:0] out_en);
        bus_write(ADDR_SIZE_LO, 8'(n));
        bus_write(ADDR_SIZE_HI, 8'(n >> 8));
        bus_write(ADDR_REP0, 8'(r));
        bus_write(ADDR_REP1, 8'(r >> 8));
        bus_write(ADDR_REP2, 8'(r >> 16));
        bus_write(ADDR_REP3, 8'(r >> 24));
        bus_write(ADDR_START_REP_LO, 8'(s));
        bus_write(ADDR_START_REP_HI, 8'(s >> 8));
        bus_write(ADDR_STOP_REP_LO, 8'(t));
        bus_write(ADDR_STOP_REP_HI, 8'(t >> 8));
        bus_write(ADDR_CONF, conf);
        bus_write(ADDR_OUT_EN, out_en);
        model_stream(n, s, t, r);
        expand_cycles(cmd_out_mode_e'(conf[2:1]), out_en, !conf[4], s);
    endtask

    // second start mid-send when restart is set, it must be ignored
    task automatic run_send(input logic use_ext, input logic restart);
        logic [7:0] fin;
        cmp_busy = 1'b1;
        -> run_cmp;
        if (use_ext) begin
            @(negedge CMD_CLK_IN);
            cmd_ext_start = 1'b1;
            @(negedge CMD_CLK_IN);
            cmd_ext_start = 1'b0;
        end else begin
            bus_write(ADDR_START, 8'h01);
        end
        bus_read(ADDR_START, fin);
        check_byte(fin, 8'h00, "finish during send");
        if (restart) bus_write(ADDR_START, 8'h01);
        wait (cmp_busy == 1'b0);
        bus_read(ADDR_START, fin);
        check_byte(fin, 8'h01, "finish after send");
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = err_cnt;
        tests_run++;
    endtask

    task automatic end_test();
        if (err_cnt == test_errs) begin
            $display("test %0d %s: ok", tests_run, test_name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, test_name, err_cnt - test_errs);
        end
    endtask

    // compares the serial side, cycle by cycle from the ready fall
    initial begin : compare_stream
        forever begin
            @(run_cmp);
            @(negedge CMD_CLK_IN);
            while (cmd_ready !== 1'b0) @(negedge CMD_CLK_IN);
            // first half-bit lands two cycles after ready falls
            @(negedge CMD_CLK_IN);
            check_lines(cmd_data, '0, "before first bit");
            for (int c = 0; c < exp_cycles; c++) begin
                @(negedge CMD_CLK_IN);
                check_lines(cmd_data, exp_line[c], $sformatf("stream cycle %0d", c));
                check_flag(cmd_start_flag, exp_flag[c], $sformatf("start flag cycle %0d", c));
                check_flag(cmd_ready, 1'b0, "ready during send");
            end
            @(negedge CMD_CLK_IN);
            check_lines(cmd_data, '0, "after last bit");
            check_flag(cmd_ready, 1'b1, "ready after send");
            cmp_busy = 1'b0;
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge CMD_CLK_IN);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", LIMIT);
        $display("Testbench failed");
        $finish;
    end

    initial begin : main
        logic [7:0] rd;
        CMD_CLK_IN = 1'b0;
        RST_CMD_CLK = 1'b1;
        req = 1'b0;
        we = 1'b0;
        addr = '0;
        wdata = 8'h00;
        cmd_ext_start = 1'b0;
        cmp_busy = 1'b0;
        seed = 32'h8d2d;
        err_cnt = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (10) @(negedge CMD_CLK_IN);
        RST_CMD_CLK = 1'b0;

        begin_test("register map");
        check_flag(cmd_ready, 1'b1, "ready after reset");
        check_lines(cmd_data, '0, "after reset");
        bus_read(ADDR_CTRL0, rd);
        check_byte(rd, 8'h01, "version");
        bus_read(ADDR_START, rd);
        check_byte(rd, 8'h01, "finish after reset");
        bus_read(ADDR_CONF, rd);
        check_mode(cmd_out_mode_e'(rd[2:1]), MODE_NRZ, "default");
        check_byte(rd, 8'h00, "conf default");
        bus_read(ADDR_SIZE_LO, rd);
        check_byte(rd, 8'h00, "size default");
        bus_read(ADDR_REP0, rd);
        check_byte(rd, 8'h01, "repeat default");
        bus_read(ADDR_REP3, rd);
        check_byte(rd, 8'h00, "repeat msb default");
        bus_read(ADDR_OUT_EN, rd);
        check_byte(rd, 8'hff, "out_en default");
        bus_write(ADDR_CONF, 8'h16);
        bus_write(ADDR_SIZE_HI, 8'h3c);
        bus_write(ADDR_REP3, 8'h81);
        bus_write(ADDR_STOP_REP_HI, 8'h7e);
        bus_write(ADDR_OUT_EN, 8'h5a);
        bus_read(ADDR_CONF, rd);
        check_byte(rd, 8'h16, "conf");
        check_mode(cmd_out_mode_e'(rd[2:1]), MODE_MANCH_THOMAS, "written");
        bus_read(ADDR_SIZE_HI, rd);
        check_byte(rd, 8'h3c, "size hi");
        bus_read(ADDR_REP3, rd);
        check_byte(rd, 8'h81, "repeat msb");
        bus_read(ADDR_STOP_REP_HI, rd);
        check_byte(rd, 8'h7e, "stop hi");
        bus_read(ADDR_OUT_EN, rd);
        check_byte(rd, 8'h5a, "out_en");
        load_pattern();
        for (int i = 0; i < PATTERN_BYTES; i++) begin
            bus_read(ADDR_MEM_BASE + ADDR_W'(i), rd);
            check_byte(rd, mem_model[i], $sformatf("memory byte %0d", i));
        end
        end_test();

        begin_test("nrz send with masked lines");
        configure_send(24, 0, 0, 1, 8'h00, 8'h05);
        run_send(1'b0, 1'b0);
        end_test();

        begin_test("repeat structure");
        configure_send(32, 5, 6, 3, 8'h00, 8'hff);
        run_send(1'b0, 1'b0);
        // same stream without the start pulse
        configure_send(32, 5, 6, 3, 8'h10, 8'hff);
        run_send(1'b0, 1'b0);
        end_test();

        begin_test("manchester");
        configure_send(16, 2, 3, 2, 8'h04, 8'hff);
        bus_read(ADDR_CONF, rd);
        check_mode(cmd_out_mode_e'(rd[2:1]), MODE_MANCH_IEEE, "ieee");
        run_send(1'b0, 1'b0);
        configure_send(16, 2, 3, 2, 8'h06, 8'h0e);
        bus_read(ADDR_CONF, rd);
        check_mode(cmd_out_mode_e'(rd[2:1]), MODE_MANCH_THOMAS, "thomas");
        run_send(1'b0, 1'b0);
        end_test();

        begin_test("handshake and status");
        configure_send(32, 5, 6, 3, 8'h00, 8'hff);
        check_flag(cmd_ready, 1'b1, "ready before send");
        run_send(1'b0, 1'b1);
        end_test();

        begin_test("external start and soft reset");
        configure_send(16, 0, 0, 1, 8'h00, 8'hff);
        check_flag(cmd_ext_start_enable, 1'b0, "ext start enable");
        @(negedge CMD_CLK_IN);
        cmd_ext_start = 1'b1;
        @(negedge CMD_CLK_IN);
        cmd_ext_start = 1'b0;
        repeat (6) begin
            @(negedge CMD_CLK_IN);
            check_flag(cmd_ready, 1'b1, "ready with ext start disabled");
        end
        configure_send(16, 0, 0, 1, 8'h01, 8'hff);
        check_flag(cmd_ext_start_enable, 1'b1, "ext start enable");
        run_send(1'b1, 1'b0);
        // long send with non-default conf and mask, cut short by a soft reset
        configure_send(64, 0, 0, 3, 8'h12, 8'h0b);
        bus_write(ADDR_START, 8'h01);
        repeat (4) @(negedge CMD_CLK_IN);
        check_flag(cmd_ready, 1'b0, "ready in mid-send");
        bus_write(ADDR_CTRL0, 8'h00);
        repeat (2) @(negedge CMD_CLK_IN);
        check_flag(cmd_ready, 1'b1, "ready after soft reset");
        check_lines(cmd_data, '0, "after soft reset");
        bus_read(ADDR_CONF, rd);
        check_byte(rd, 8'h00, "conf after soft reset");
        bus_read(ADDR_SIZE_LO, rd);
        check_byte(rd, 8'h00, "size after soft reset");
        bus_read(ADDR_REP0, rd);
        check_byte(rd, 8'h01, "repeat after soft reset");
        bus_read(ADDR_OUT_EN, rd);
        check_byte(rd, 8'hff, "out_en after soft reset");
        bus_read(ADDR_START, rd);
        check_byte(rd, 8'h01, "finish after soft reset");
        bus_read(ADDR_MEM_BASE, rd);
        check_byte(rd, mem_model[0], "memory kept");
        end_test();

        $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
design/cmd_seq_pkg.sv
design/cmd_seq_regs.sv
design/cmd_seq_mem.sv
design/cmd_seq_ctrl.sv
design/cmd_seq_serializer.sv
design/cmd_seq_top.sv
tb/cmd_seq_tb.sv

// File: Bender.yml
package:
  name: cmd_seq

sources:
  - files:
      - design/cmd_seq_pkg.sv
      - design/cmd_seq_regs.sv
      - design/cmd_seq_mem.sv
      - design/cmd_seq_ctrl.sv
      - design/cmd_seq_serializer.sv
      - design/cmd_seq_top.sv
  - target: test
    files:
      - tb/cmd_seq_tb.sv
